/* tb.f */
+incdir+.
cache_pkg.sv
data_ram.sv
tag_ram.sv
lookup_issue.sv
hit_resolve.sv
dcache_top.sv
tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dcache
FILELIST  ?= tb.f

OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_dcache;
    import cache_pkg::*;

    // stimulus length per test, in cycles
    localparam int CYC_RESET      = 16;
    localparam int CYC_RESET_MISS = 16;
    localparam int CYC_FILL_HIT   = 20;
    localparam int CYC_STORE      = 52;
    localparam int CYC_REPLACE    = 20;
    localparam int CYC_B2B        = 36;
    localparam int CYC_TOTAL      = CYC_RESET + CYC_RESET_MISS + CYC_FILL_HIT
                                  + CYC_STORE + CYC_REPLACE + CYC_B2B;
    localparam int CYCLE_LIMIT    = CYC_TOTAL * 3 / 2;

    logic     i_clk;
    logic     i_rst;
    logic     i_req;
    logic     i_wr;
    logic     i_fill;
    addr_t    i_addr;
    word_t    i_wdata;
    byte_en_t i_wbyteen;
    logic     o_resp_valid;
    logic     o_hit;
    word_t    o_rdata;

    // reference model of the line arrays
    logic  m_valid [`CACHE_LINES];
    tag_t  m_tag   [`CACHE_LINES];
    word_t m_data  [`CACHE_LINES];

    // expected response, set with the strobe and delayed two cycles
    logic  exp_load, exp_load_d1, exp_load_d2;
    logic  exp_hit, exp_hit_d1, exp_hit_d2;
    word_t exp_data, exp_data_d1, exp_data_d2;

    index_t      idx_pool [4] = '{6'd3, 6'd17, 6'd40, 6'd63};
    tag_t        tag_pool [2] = '{24'h00A5C3, 24'h5A1F00};
    logic [15:0] lfsr_state   = 16'd22077;
    string       test_name    = "reset_miss";
    int          value_errors  = 0;
    int          timing_errors = 0;
    int          cycle_count   = 0;

    dcache_top dut0 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req        (i_req),
        .i_wr         (i_wr),
        .i_fill       (i_fill),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_wbyteen    (i_wbyteen),
        .o_resp_valid (o_resp_valid),
        .o_hit        (o_hit),
        .o_rdata      (o_rdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic word_t draw_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic index_t pick_index();
        word_t rnd;
        rnd = draw_bits(2);
        return idx_pool[rnd[1:0]];
    endfunction

    function automatic tag_t pick_tag();
        word_t rnd;
        rnd = draw_bits(1);
        return tag_pool[rnd[0]];
    endfunction

    function automatic tag_t other_tag(input tag_t t);
        return (t == tag_pool[0]) ? tag_pool[1] : tag_pool[0];
    endfunction

    function automatic byte_en_t random_byteen();
        word_t rnd;
        rnd = draw_bits(4);
        return (rnd[3:0] == 4'h0) ? 4'hf : rnd[3:0];   // an empty store is not legal
    endfunction

    // one cycle of stimulus, model updated in issue order
    task automatic drive_op(input cache_op_e kind, input index_t idx, input tag_t tag,
                            input word_t data, input byte_en_t be);
        word_t rnd;
        word_t merged;
        logic  hit;
        rnd    = draw_bits(2);   // byte offset, ignored by the cache
        hit    = m_valid[idx] && (m_tag[idx] == tag);
        merged = m_data[idx];
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        @(posedge i_clk);
        #2;
        i_req     = (kind == OP_LOAD);
        i_wr      = (kind == OP_STORE);
        i_fill    = (kind == OP_FILL);
        i_addr    = {tag, idx, rnd[1:0]};
        i_wdata   = data;
        i_wbyteen = be;
        exp_load  = (kind == OP_LOAD);
        exp_hit   = (kind == OP_LOAD) && hit;
        exp_data  = m_data[idx];
        if (kind == OP_STORE && hit) begin
            m_data[idx] = merged;
        end else if (kind == OP_FILL) begin
            m_valid[idx] = 1'b1;
            m_tag[idx]   = tag;
            m_data[idx]  = data;
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            drive_op(OP_NONE, '0, '0, '0, '0);
        end
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            exp_load_d1 <= 1'b0;
            exp_load_d2 <= 1'b0;
            exp_hit_d1  <= 1'b0;
            exp_hit_d2  <= 1'b0;
            exp_data_d1 <= '0;
            exp_data_d2 <= '0;
        end else begin
            exp_load_d1 <= exp_load;
            exp_load_d2 <= exp_load_d1;
            exp_hit_d1  <= exp_hit;
            exp_hit_d2  <= exp_hit_d1;
            exp_data_d1 <= exp_data;
            exp_data_d2 <= exp_data_d1;
        end
    end

    a_resp_timing: assert property (@(posedge i_clk) disable iff (i_rst)
        o_resp_valid == exp_load_d2)
    else begin
        timing_errors = timing_errors + 1;
        $display("** Error [%s] o_resp_valid: expected %0b, actual %0b",
                 test_name, $sampled(exp_load_d2), $sampled(o_resp_valid));
    end

    a_resp_hit: assert property (@(posedge i_clk) disable iff (i_rst)
        o_resp_valid |-> (o_hit == exp_hit_d2))
    else begin
        value_errors = value_errors + 1;
        $display("** Error [%s] o_hit: expected %0b, actual %0b",
                 test_name, $sampled(exp_hit_d2), $sampled(o_hit));
    end

    a_resp_data: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_resp_valid && exp_hit_d2) |-> (o_rdata == exp_data_d2))
    else begin
        value_errors = value_errors + 1;
        $display("** Error [%s] o_rdata: expected %08h, actual %08h",
                 test_name, $sampled(exp_data_d2), $sampled(o_rdata));
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        index_t idx;
        tag_t   tag;
        tag_t   old_tag;
        i_rst     = 1'b1;
        i_req     = 1'b0;
        i_wr      = 1'b0;
        i_fill    = 1'b0;
        i_addr    = '0;
        i_wdata   = '0;
        i_wbyteen = '0;
        exp_load  = 1'b0;
        exp_hit   = 1'b0;
        exp_data  = '0;
        for (int i = 0; i < `CACHE_LINES; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (CYC_RESET) @(posedge i_clk);
        #2;
        i_rst = 1'b0;

        // nothing valid yet, every load misses
        idle_cycles(4);
        for (int i = 0; i < 8; i++) begin
            drive_op(OP_LOAD, idx_pool[i % 4], tag_pool[i / 4], '0, '0);
        end
        idle_cycles(4);

        test_name = "fill_hit";
        for (int i = 0; i < 4; i++) begin
            tag = pick_tag();
            drive_op(OP_FILL, idx_pool[i], tag, draw_bits(32), '0);
            idle_cycles(1);
            drive_op(OP_LOAD, idx_pool[i], tag, '0, '0);
            drive_op(OP_LOAD, idx_pool[i], other_tag(tag), '0, '0);
        end
        idle_cycles(4);

        // random tag, so roughly half the stores miss
        test_name = "store_merge";
        for (int i = 0; i < 12; i++) begin
            idx = pick_index();
            tag = pick_tag();
            drive_op(OP_STORE, idx, tag, draw_bits(32), random_byteen());
            idle_cycles(1);
            drive_op(OP_LOAD, idx, tag, '0, '0);
            drive_op(OP_LOAD, idx, m_tag[idx], '0, '0);   // resident word
        end
        idle_cycles(4);

        test_name = "fill_replace";
        for (int i = 0; i < 4; i++) begin
            old_tag = m_tag[idx_pool[i]];
            drive_op(OP_FILL, idx_pool[i], other_tag(old_tag), draw_bits(32), '0);
            idle_cycles(1);
            drive_op(OP_LOAD, idx_pool[i], old_tag, '0, '0);
            drive_op(OP_LOAD, idx_pool[i], other_tag(old_tag), '0, '0);
        end
        idle_cycles(4);

        // write then load of the same line in the next cycle
        test_name = "back_to_back";
        for (int i = 0; i < 12; i++) begin
            idx = pick_index();
            tag = pick_tag();
            if (draw_bits(1) == 32'd1) begin
                drive_op(OP_FILL, idx, tag, draw_bits(32), '0);
            end else begin
                drive_op(OP_STORE, idx, tag, draw_bits(32), random_byteen());
            end
            drive_op(OP_LOAD, idx, m_tag[idx], '0, '0);
        end
        for (int i = 0; i < 8; i++) begin
            drive_op(OP_LOAD, pick_index(), pick_tag(), '0, '0);
        end
        idle_cycles(4);

        @(posedge i_clk);
        #2;
        $display("checks done, %0d value errors, %0d timing errors",
                 value_errors, timing_errors);
        if (value_errors + timing_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module dcache_top (
    input  wire                       i_clk,
    input  wire                       i_rst,

    input  wire                       i_req,
    input  wire                       i_wr,
    input  wire                       i_fill,
    input  wire cache_pkg::addr_t     i_addr,
    input  wire cache_pkg::word_t     i_wdata,
    input  wire cache_pkg::byte_en_t  i_wbyteen,

    output logic                      o_resp_valid,
    output logic                      o_hit,
    output cache_pkg::word_t          o_rdata
);
    import cache_pkg::*;

    index_t     w_raddr;       // shared read index of both rams
    cache_op_t  w_s1_op;
    tag_entry_t w_rtag;
    word_t      w_rdata;

    logic       w_tag_wen;
    index_t     w_tag_waddr;
    tag_entry_t w_wtag;
    logic       w_data_wen;
    index_t     w_data_waddr;
    word_t      w_wdata;
    byte_en_t   w_wbyteen;

    lookup_issue u_issue (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_req     (i_req),
        .i_wr      (i_wr),
        .i_fill    (i_fill),
        .i_addr    (i_addr),
        .i_wdata   (i_wdata),
        .i_wbyteen (i_wbyteen),
        .o_raddr   (w_raddr),
        .o_op      (w_s1_op)
    );

    data_ram #(
        .INDEX_WIDTH (`CACHE_INDEX_WIDTH)
    ) u_data_ram (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wen     (w_data_wen),
        .i_wbyteen (w_wbyteen),
        .i_raddr   (w_raddr),
        .i_waddr   (w_data_waddr),
        .i_wdata   (w_wdata),
        .o_rdata   (w_rdata)
    );

    tag_ram #(
        .INDEX_WIDTH (`CACHE_INDEX_WIDTH),
        .TAG_WIDTH   (`CACHE_TAG_WIDTH)
    ) u_tag_ram (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wen   (w_tag_wen),
        .i_raddr (w_raddr),
        .i_waddr (w_tag_waddr),
        .i_wtag  (w_wtag),
        .o_rtag  (w_rtag)
    );

    hit_resolve u_resolve (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_op         (w_s1_op),
        .i_rtag       (w_rtag),
        .i_rdata      (w_rdata),
        .o_tag_wen    (w_tag_wen),
        .o_tag_waddr  (w_tag_waddr),
        .o_wtag       (w_wtag),
        .o_data_wen   (w_data_wen),
        .o_data_waddr (w_data_waddr),
        .o_wdata      (w_wdata),
        .o_wbyteen    (w_wbyteen),
        .o_resp_valid (o_resp_valid),
        .o_hit        (o_hit),
        .o_rdata      (o_rdata)
    );

endmodule

`default_nettype wire

/* hit_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module hit_resolve (
    input  wire                         i_clk,
    input  wire                         i_rst,

    input  wire cache_pkg::cache_op_t   i_op,
    input  wire cache_pkg::tag_entry_t  i_rtag,
    input  wire cache_pkg::word_t       i_rdata,

    // tag ram write port
    output logic                        o_tag_wen,
    output cache_pkg::index_t           o_tag_waddr,
    output cache_pkg::tag_entry_t       o_wtag,

    // data ram write port
    output logic                        o_data_wen,
    output cache_pkg::index_t           o_data_waddr,
    output cache_pkg::word_t            o_wdata,
    output cache_pkg::byte_en_t         o_wbyteen,

    output logic                        o_resp_valid,
    output logic                        o_hit,
    output cache_pkg::word_t            o_rdata
);
    import cache_pkg::*;

    logic [`CACHE_LINES-1:0] r_valid;    // the only state cleared by reset
    logic                    w_is_load;
    logic                    w_is_store;
    logic                    w_is_fill;
    logic                    w_hit;

    assign w_is_load  = (i_op.op == OP_LOAD);
    assign w_is_store = (i_op.op == OP_STORE);
    assign w_is_fill  = (i_op.op == OP_FILL);

    assign w_hit = r_valid[i_op.index] && i_rtag.valid && (i_rtag.tag == i_op.tag);

    always_comb begin
        o_tag_wen    = w_is_fill;
        o_tag_waddr  = i_op.index;
        o_wtag.valid = 1'b1;
        o_wtag.tag   = i_op.tag;

        // write-through, no allocate on a store miss
        o_data_wen   = w_is_fill || (w_is_store && w_hit);
        o_data_waddr = i_op.index;
        o_wdata      = i_op.wdata;
        o_wbyteen    = w_is_fill ? '1 : i_op.wbyteen;   // refill writes the whole word
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_valid <= '0;
        end else if (w_is_fill) begin
            r_valid[i_op.index] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= w_is_load;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_is_load) begin
            o_hit   <= w_hit;
            o_rdata <= w_hit ? i_rdata : '0;   // zero on a miss
        end
    end

    // stage one is cleared a cycle into reset, so no ram write follows
    a_no_write_in_reset: assert property (@(posedge i_clk)
        i_rst |=> !(o_tag_wen || o_data_wen));

endmodule

`default_nettype wire

/* lookup_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module lookup_issue (
    input  wire                       i_clk,
    input  wire                       i_rst,

    input  wire                       i_req,      // load
    input  wire                       i_wr,       // store
    input  wire                       i_fill,
    input  wire cache_pkg::addr_t     i_addr,
    input  wire cache_pkg::word_t     i_wdata,
    input  wire cache_pkg::byte_en_t  i_wbyteen,

    output cache_pkg::index_t         o_raddr,
    output cache_pkg::cache_op_t      o_op
);
    import cache_pkg::*;

    cache_op_t w_op;

    always_comb begin
        if (i_req) begin
            w_op.op = OP_LOAD;
        end else if (i_wr) begin
            w_op.op = OP_STORE;
        end else if (i_fill) begin
            w_op.op = OP_FILL;
        end else begin
            w_op.op = OP_NONE;
        end
        w_op.tag     = i_addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
        w_op.index   = i_addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
        w_op.wdata   = i_wdata;
        w_op.wbyteen = i_wbyteen;
    end

    // both rams look up this cycle, results line up with o_op
    assign o_raddr = w_op.index;

    always_ff @(posedge i_clk) begin
        o_op <= w_op;
        if (i_rst) begin
            o_op.op <= OP_NONE;   // payload fields left as they are
        end
    end

    // no arbitration here, the requester keeps strobes exclusive
    a_one_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0({i_req, i_wr, i_fill}));

endmodule

`default_nettype wire

/* tag_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tag_ram #(
    parameter int INDEX_WIDTH = `CACHE_INDEX_WIDTH,
    parameter int TAG_WIDTH   = `CACHE_TAG_WIDTH
) (
    input  wire                    i_clk,
    input  wire                    i_rst,

    input  wire                    i_wen,
    input  wire [INDEX_WIDTH-1:0]  i_raddr,
    input  wire [INDEX_WIDTH-1:0]  i_waddr,
    input  wire [TAG_WIDTH:0]      i_wtag,    // {valid, tag}
    output logic [TAG_WIDTH:0]     o_rtag
);

    localparam int DEPTH = 1 << INDEX_WIDTH;

    logic [TAG_WIDTH:0] mem [DEPTH];
    logic [TAG_WIDTH:0] r_rtag;
    logic [TAG_WIDTH:0] r_wtag;
    logic               w_isforward;
    logic               r_isforward;

    // decided before the edge, unlike data_ram
    assign w_isforward = i_wen && (i_raddr == i_waddr);

    always_ff @(posedge i_clk) begin
        if (i_wen) begin
            mem[i_waddr] <= i_wtag;
            r_wtag       <= i_wtag;
        end
        r_rtag <= mem[i_raddr];
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_isforward <= 1'b0;
        end else begin
            r_isforward <= w_isforward;
        end
    end

    assign o_rtag = r_isforward ? r_wtag : r_rtag;

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module data_ram #(
    parameter int INDEX_WIDTH = `CACHE_INDEX_WIDTH
) (
    input  wire                       i_clk,
    input  wire                       i_rst,

    input  wire                       i_wen,
    input  wire cache_pkg::byte_en_t  i_wbyteen,
    input  wire [INDEX_WIDTH-1:0]     i_raddr,
    input  wire [INDEX_WIDTH-1:0]     i_waddr,
    input  wire cache_pkg::word_t     i_wdata,
    output cache_pkg::word_t          o_rdata
);
    import cache_pkg::*;

    localparam int DEPTH  = 1 << INDEX_WIDTH;
    localparam int NBYTES = $bits(byte_en_t);

    word_t                  mem [DEPTH];
    word_t                  w_merged;     // line after the byte merge
    word_t                  r_rdata;      // read port output
    word_t                  r_wword;      // write port output, new content
    logic                   r_wen;
    logic [INDEX_WIDTH-1:0] r_raddr;
    logic [INDEX_WIDTH-1:0] r_waddr;
    logic                   w_isforward;

    always_comb begin
        w_merged = mem[i_waddr];
        for (int b = 0; b < NBYTES; b++) begin
            if (i_wbyteen[b]) begin
                w_merged[8*b +: 8] = i_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wen) begin
            mem[i_waddr] <= w_merged;
            r_wword      <= w_merged;
        end
        r_rdata <= mem[i_raddr];   // old content on a same-edge write
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_wen   <= 1'b0;
            r_raddr <= '0;
            r_waddr <= '0;
        end else begin
            r_wen   <= i_wen;
            r_raddr <= i_raddr;
            r_waddr <= i_waddr;
        end
    end

    // write committed at the read edge wins
    assign w_isforward = r_wen && (r_raddr == r_waddr);
    assign o_rdata     = w_isforward ? r_wword : r_rdata;

    // hit_resolve must never issue an empty write
    a_wbyteen_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wen |-> (i_wbyteen != '0));

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`CACHE_INDEX_WIDTH-1:0]   index_t;
    typedef logic [`CACHE_TAG_WIDTH-1:0]     tag_t;
    typedef logic [`CACHE_WORD_WIDTH-1:0]    word_t;
    typedef logic [`CACHE_WORD_WIDTH/8-1:0]  byte_en_t;   // one per byte lane

    // what the tag ram holds per line
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE,
        OP_FILL
    } cache_op_e;

    // stage one contents, request with address already split
    typedef struct packed {
        cache_op_e op;
        tag_t      tag;
        index_t    index;
        word_t     wdata;
        byte_en_t  wbyteen;
    } cache_op_t;

endpackage

`default_nettype wire

/* cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// byte address layout is tag | index | offset
`define CACHE_ADDR_WIDTH   32
`define CACHE_INDEX_WIDTH  6
`define CACHE_OFFSET_WIDTH 2
`define CACHE_TAG_WIDTH    (`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH - `CACHE_OFFSET_WIDTH)

`define CACHE_WORD_WIDTH   32
`define CACHE_LINES        (1 << `CACHE_INDEX_WIDTH)   // one word per line

`endif
